//--- cache_geom_pkg.sv
package cache_geom_pkg;

	// geometry
	// --------------------
	// fully associative, so one set of N_LINES ways
	localparam int N_LINES = 8;
	localparam int LINE_W  = $clog2(N_LINES);
	localparam int TAG_W   = 12;

	// types
	// --------------------
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [LINE_W-1:0] line_t;

	// one lookup outcome, payload of the result queue
	typedef struct packed {
		logic  hit;
		line_t line;
	} lookup_res_t;

endpackage

//--- apb_map_pkg.sv
package apb_map_pkg;

	// bus widths
	// --------------------
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// register offsets
	// --------------------
	localparam logic [APB_AW-1:0] REG_LOOKUP = 8'h00;
	localparam logic [APB_AW-1:0] REG_RESULT = 8'h04;
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h08;

	// status bits
	localparam int ST_REQ_FULL  = 0;
	localparam int ST_RES_EMPTY = 1;

	// queue depths
	localparam int REQ_DEPTH = 4;
	localparam int RES_DEPTH = 4;

endpackage

//--- priority_encoder.sv
`timescale 1ns/1ps

module priority_encoder #(
	parameter int WIDTH = 8
) (
	input  logic [WIDTH-1:0]         bits_i,
	output logic [$clog2(WIDTH)-1:0] index_o
);

	// walk from the top down so the lowest set bit is the last one written
	// an all-zero vector falls through to index 0
	always_comb begin
		index_o = '0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			if (bits_i[i]) begin
				index_o = i[$clog2(WIDTH)-1:0];
			end
		end
	end

endmodule

//--- line_replacement_ctrl.sv
`timescale 1ns/1ps

module line_replacement_ctrl import cache_geom_pkg::*; (
	input  logic  clock_i,
	input  logic  resetn_i,
	input  logic  touch_i,
	input  line_t touch_line_i,
	input  logic  alloc_i,
	output logic  victim_valid_o,
	output line_t victim_line_o
);

	// rank per line, 0 is MRU and N_LINES-1 is LRU
	line_t rank_q [N_LINES];
	line_t old_rank;

	// cold start fill state
	line_t fill_cnt_q;
	logic  full_q;

	logic  victim_valid_q;
	line_t victim_line_q;

	// LRU select
	// --------------------
	logic [N_LINES-1:0] is_lru;
	line_t              lru_line;

	always_comb begin
		for (int i = 0; i < N_LINES; i++) begin
			is_lru[i] = (rank_q[i] == line_t'(N_LINES - 1));
		end
	end

	// ranks are a permutation, so only one bit of is_lru is set
	priority_encoder #(
		.WIDTH (N_LINES)
	) i_lru_enc (
		.bits_i  (is_lru),
		.index_o (lru_line)
	);

	assign old_rank = rank_q[touch_line_i];

	// rank stack and fill counter
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			// initial order is line 0 as MRU down to the last line as LRU
			for (int i = 0; i < N_LINES; i++) begin
				rank_q[i] <= line_t'(i);
			end
			fill_cnt_q     <= '0;
			full_q         <= 1'b0;
			victim_valid_q <= 1'b0;
		end else begin
			// victim answer comes one cycle after the request
			victim_valid_q <= alloc_i;
			if (touch_i) begin
				// touched line to the front, everything more recent moves back one
				for (int i = 0; i < N_LINES; i++) begin
					if (line_t'(i) == touch_line_i) begin
						rank_q[i] <= '0;
					end else if (rank_q[i] < old_rank) begin
						rank_q[i] <= rank_q[i] + 1'b1;
					end
				end
			end
			if (alloc_i && !full_q) begin
				fill_cnt_q <= fill_cnt_q + 1'b1;
				// last free line handed out
				if (fill_cnt_q == line_t'(N_LINES - 1)) begin
					full_q <= 1'b1;
				end
			end
		end
	end

	// free lines in order until full, then evict the LRU line
	always_ff @(posedge clock_i) begin
		if (alloc_i) begin
			victim_line_q <= full_q ? lru_line : fill_cnt_q;
		end
	end

	assign victim_valid_o = victim_valid_q;
	assign victim_line_o  = victim_line_q;

	// checks
	// --------------------
	a_one_lru : assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot(is_lru));

	a_no_touch_alloc : assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(alloc_i && touch_i));

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clock_i,
	input  logic     resetn_i,
	input  logic     push_i,
	input  payload_t data_i,
	input  logic     pop_i,
	output payload_t head_o,
	output logic     full_o,
	output logic     empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t           mem_q [DEPTH];
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [PTR_W-1:0]   rd_ptr_q;
	// one extra bit so a full buffer is distinct from an empty one
	logic [PTR_W:0]     count_q;

	// storage, no reset on the payload
	always_ff @(posedge clock_i) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= data_i;
		end
	end

	// pointers and occupancy
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (push_i && !pop_i) begin
				count_q <= count_q + 1'b1;
			end else if (pop_i && !push_i) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// head read straight from the array
	assign head_o  = mem_q[rd_ptr_q];
	assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
	assign empty_o = (count_q == '0);

	a_no_overflow : assert property (@(posedge clock_i) disable iff (!resetn_i)
		push_i |-> !full_o);

	a_no_underflow : assert property (@(posedge clock_i) disable iff (!resetn_i)
		pop_i |-> !empty_o);

endmodule

//--- apb_lookup_port.sv
`timescale 1ns/1ps

module apb_lookup_port import cache_geom_pkg::*, apb_map_pkg::*; (
	// APB slave
	input  logic [APB_AW-1:0] paddr_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_DW-1:0] pwdata_i,
	output logic [APB_DW-1:0] prdata_o,
	output logic              pready_o,
	output logic              pslverr_o,
	// request queue side
	output logic              req_push_o,
	output tag_t              req_data_o,
	input  logic              req_full_i,
	// result queue side
	output logic              res_pop_o,
	input  lookup_res_t       res_head_i,
	input  logic              res_empty_i
);

	logic access;
	logic wr_lookup;
	logic rd_result;
	logic rd_status;
	logic unmapped;

	// decode
	// --------------------
	// only the access phase does anything
	assign access    = psel_i && penable_i;
	assign wr_lookup = access && pwrite_i && (paddr_i == REG_LOOKUP);
	assign rd_result = access && !pwrite_i && (paddr_i == REG_RESULT);
	assign rd_status = access && !pwrite_i && (paddr_i == REG_STATUS);
	// any other offset or direction is an error
	assign unmapped  = access && !wr_lookup && !rd_result && !rd_status;

	// one push per legal lookup write, dropped when the queue is full
	assign req_push_o = wr_lookup && !req_full_i;
	assign req_data_o = pwdata_i[TAG_W-1:0];

	// one pop per legal result read
	assign res_pop_o = rd_result && !res_empty_i;

	// no wait states
	assign pready_o = 1'b1;

	// read data
	// --------------------
	always_comb begin
		prdata_o = '0;
		if (rd_result && !res_empty_i) begin
			// hit flag at bit 8, line index in the low bits
			prdata_o[8]          = res_head_i.hit;
			prdata_o[LINE_W-1:0] = res_head_i.line;
		end else if (rd_status) begin
			prdata_o[ST_REQ_FULL]  = req_full_i;
			prdata_o[ST_RES_EMPTY] = res_empty_i;
		end
	end

	// error response
	assign pslverr_o = (wr_lookup && req_full_i) ||
		(rd_result && res_empty_i) ||
		unmapped;

endmodule

//--- tag_lookup_engine.sv
`timescale 1ns/1ps

module tag_lookup_engine import cache_geom_pkg::*; (
	input  logic        clock_i,
	input  logic        resetn_i,
	// request queue
	input  tag_t        req_head_i,
	input  logic        req_empty_i,
	output logic        req_pop_o,
	// result queue
	output logic        res_push_o,
	output lookup_res_t res_data_o,
	input  logic        res_full_i,
	// replacement controller
	output logic        alloc_o,
	input  logic        victim_valid_i,
	input  line_t       victim_line_i,
	output logic        touch_o,
	output line_t       touch_line_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ALLOC,
		ST_WRITE
	} state_t;

	state_t state_q;

	// tag store
	logic [N_LINES-1:0] valid_q;
	tag_t               tag_q [N_LINES];
	line_t              victim_q;

	logic [N_LINES-1:0] hit_vec;
	logic               hit;
	line_t              hit_line;
	logic               take;
	logic               in_write;
	logic               dup_tag;

	// compare
	// --------------------
	// head tag against every valid line at once
	always_comb begin
		hit_line = '0;
		for (int i = 0; i < N_LINES; i++) begin
			hit_vec[i] = valid_q[i] && (tag_q[i] == req_head_i);
		end
		for (int i = N_LINES - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				hit_line = line_t'(i);
			end
		end
	end

	assign hit = |hit_vec;

	// new request only with room for its result
	assign take     = (state_q == ST_IDLE) && !req_empty_i && !res_full_i;
	assign in_write = (state_q == ST_WRITE);

	// handshakes
	// --------------------
	// a hit finishes in idle, a miss finishes in write
	assign req_pop_o    = (take && hit) || in_write;
	assign res_push_o   = (take && hit) || in_write;
	assign alloc_o      = take && !hit;
	assign touch_o      = (take && hit) || in_write;
	assign touch_line_o = in_write ? victim_q : hit_line;

	assign res_data_o.hit  = !in_write;
	assign res_data_o.line = touch_line_o;

	// FSM and valid bits
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= ST_IDLE;
			valid_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (alloc_o) begin
						state_q <= ST_ALLOC;
					end
				end
				ST_ALLOC: begin
					// wait for the controller answer
					if (victim_valid_i) begin
						state_q <= ST_WRITE;
					end
				end
				ST_WRITE: begin
					valid_q[victim_q] <= 1'b1;
					state_q           <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// victim and tag payload
	always_ff @(posedge clock_i) begin
		if ((state_q == ST_ALLOC) && victim_valid_i) begin
			victim_q <= victim_line_i;
		end
		// head is still the missing tag, it was not popped yet
		if (in_write) begin
			tag_q[victim_q] <= req_head_i;
		end
	end

	// checks
	// --------------------
	always_comb begin
		dup_tag = 1'b0;
		for (int i = 0; i < N_LINES; i++) begin
			for (int j = i + 1; j < N_LINES; j++) begin
				if (valid_q[i] && valid_q[j] && (tag_q[i] == tag_q[j])) begin
					dup_tag = 1'b1;
				end
			end
		end
	end

	a_unique_tags : assert property (@(posedge clock_i) disable iff (!resetn_i)
		!dup_tag);

endmodule

//--- cache_tag_top.sv
`timescale 1ns/1ps

module cache_tag_top import cache_geom_pkg::*, apb_map_pkg::*; (
	input  logic              clock_i,
	input  logic              resetn_i,
	// APB
	input  logic [APB_AW-1:0] paddr_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_DW-1:0] pwdata_i,
	output logic [APB_DW-1:0] prdata_o,
	output logic              pready_o,
	output logic              pslverr_o
);

	// request path
	logic        req_push;
	tag_t        req_data;
	logic        req_full;
	logic        req_pop;
	tag_t        req_head;
	logic        req_empty;

	// result path
	logic        res_push;
	lookup_res_t res_data;
	logic        res_full;
	logic        res_pop;
	lookup_res_t res_head;
	logic        res_empty;

	// replacement handshake
	logic        alloc;
	logic        victim_valid;
	line_t       victim_line;
	logic        touch;
	line_t       touch_line;

	// producer
	// --------------------
	apb_lookup_port i_apb_lookup_port (
		.paddr_i     (paddr_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.req_push_o  (req_push),
		.req_data_o  (req_data),
		.req_full_i  (req_full),
		.res_pop_o   (res_pop),
		.res_head_i  (res_head),
		.res_empty_i (res_empty)
	);

	// buffers
	// --------------------
	sync_fifo #(
		.payload_t (tag_t),
		.DEPTH     (REQ_DEPTH)
	) i_req_fifo (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.push_i   (req_push),
		.data_i   (req_data),
		.pop_i    (req_pop),
		.head_o   (req_head),
		.full_o   (req_full),
		.empty_o  (req_empty)
	);

	sync_fifo #(
		.payload_t (lookup_res_t),
		.DEPTH     (RES_DEPTH)
	) i_res_fifo (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.push_i   (res_push),
		.data_i   (res_data),
		.pop_i    (res_pop),
		.head_o   (res_head),
		.full_o   (res_full),
		.empty_o  (res_empty)
	);

	// consumer
	// --------------------
	tag_lookup_engine i_tag_lookup_engine (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.req_head_i     (req_head),
		.req_empty_i    (req_empty),
		.req_pop_o      (req_pop),
		.res_push_o     (res_push),
		.res_data_o     (res_data),
		.res_full_i     (res_full),
		.alloc_o        (alloc),
		.victim_valid_i (victim_valid),
		.victim_line_i  (victim_line),
		.touch_o        (touch),
		.touch_line_o   (touch_line)
	);

	// LRU victim choice
	line_replacement_ctrl i_line_replacement_ctrl (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.touch_i        (touch),
		.touch_line_i   (touch_line),
		.alloc_i        (alloc),
		.victim_valid_o (victim_valid),
		.victim_line_o  (victim_line)
	);

endmodule

//--- tb_cache_tag.sv
`timescale 1ns/1ps

module tb_cache_tag import cache_geom_pkg::*, apb_map_pkg::*; ();

	localparam int CLK_PERIOD     = 40;
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int MAX_POLLS      = 50;
	localparam int RAND_SEED      = 44250;
	// both queues together, no result read
	localparam int BP_LOOKUPS     = REQ_DEPTH + RES_DEPTH;
	localparam logic [APB_AW-1:0] REG_UNMAPPED = 8'h0C;

	logic              clock;
	logic              resetn;
	logic [APB_AW-1:0] paddr;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic              pready;
	logic              pslverr;

	// reference model state
	tag_t mdl_tag [N_LINES];
	logic mdl_valid [N_LINES];
	int   mdl_rank [N_LINES];
	int   mdl_fill;

	int cycle_cnt;

	cache_tag_top i_cache_tag_top (
		.clock_i   (clock),
		.resetn_i  (resetn),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clock = ~clock;
		end
	end

	// run limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_cnt++;
		end
		$display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
		stop_run();
	end

	// checking
	// --------------------
	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_run();
		end
	endtask

	// APB master
	// --------------------
	// setup on one falling edge, access on the next, sampled mid access
	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
		output logic err);
		@(negedge clock);
		paddr   = addr;
		pwrite  = 1'b1;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clock);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		err = pslverr;
		check_value("pready", 32'(pready), 32'h1);
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
		output logic err);
		@(negedge clock);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clock);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		data = prdata;
		err  = pslverr;
		check_value("pready", 32'(pready), 32'h1);
		@(negedge clock);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// reference LRU model
	// --------------------
	task automatic model_reset();
		for (int i = 0; i < N_LINES; i++) begin
			mdl_valid[i] = 1'b0;
			mdl_tag[i]   = '0;
			// line 0 starts as MRU, last line as LRU
			mdl_rank[i]  = i;
		end
		mdl_fill = 0;
	endtask

	task automatic model_touch(input int line);
		int old_rank;
		old_rank = mdl_rank[line];
		for (int i = 0; i < N_LINES; i++) begin
			if (i == line) begin
				mdl_rank[i] = 0;
			end else if (mdl_rank[i] < old_rank) begin
				mdl_rank[i]++;
			end
		end
	endtask

	task automatic model_lookup(input tag_t tag, output logic hit, output int line);
		hit  = 1'b0;
		line = 0;
		for (int i = 0; i < N_LINES; i++) begin
			if (mdl_valid[i] && (mdl_tag[i] == tag)) begin
				hit  = 1'b1;
				line = i;
			end
		end
		if (!hit) begin
			// free lines in order first, then the LRU line
			if (mdl_fill < N_LINES) begin
				line = mdl_fill;
				mdl_fill++;
			end else begin
				for (int i = 0; i < N_LINES; i++) begin
					if (mdl_rank[i] == N_LINES - 1) begin
						line = i;
					end
				end
			end
			mdl_tag[line]   = tag;
			mdl_valid[line] = 1'b1;
		end
		model_touch(line);
	endtask

	// hit flag at bit 8, line in the low bits
	function automatic logic [31:0] result_word(input logic hit, input int line);
		result_word              = '0;
		result_word[8]           = hit;
		result_word[LINE_W-1:0]  = line[LINE_W-1:0];
	endfunction

	function automatic tag_t cold_tag(input int i);
		cold_tag = tag_t'(32'h100 + 32'(i) * 32'h11);
	endfunction

	// lookup helpers
	// --------------------
	task automatic wait_result();
		logic [31:0] status;
		logic        err;
		int          polls;
		polls = 0;
		apb_read(REG_STATUS, status, err);
		while (status[ST_RES_EMPTY]) begin
			polls++;
			if (polls > MAX_POLLS) begin
				$display("no result came out after %0d STATUS polls", MAX_POLLS);
				stop_run();
			end
			apb_read(REG_STATUS, status, err);
		end
	endtask

	task automatic lookup_check(input tag_t tag, output logic [31:0] word);
		logic        err;
		logic        hit;
		int          line;
		logic [31:0] data;
		apb_write(REG_LOOKUP, 32'(tag), err);
		check_value("pslverr on LOOKUP write", 32'(err), 32'h0);
		model_lookup(tag, hit, line);
		wait_result();
		apb_read(REG_RESULT, data, err);
		check_value("pslverr on RESULT read", 32'(err), 32'h0);
		check_value("RESULT", data, result_word(hit, line));
		word = data;
	endtask

	// directed tests
	// --------------------
	task automatic test_after_reset();
		logic [31:0] data;
		logic        err;
		apb_read(REG_STATUS, data, err);
		check_value("STATUS after reset", data, 32'(1 << ST_RES_EMPTY));
		check_value("pslverr on STATUS read", 32'(err), 32'h0);
		// empty result queue
		apb_read(REG_RESULT, data, err);
		check_value("RESULT when empty", data, 32'h0);
		check_value("pslverr on empty RESULT read", 32'(err), 32'h1);
		apb_read(REG_UNMAPPED, data, err);
		check_value("pslverr on unmapped read", 32'(err), 32'h1);
	endtask

	task automatic test_cold_fill();
		logic [31:0] word;
		for (int i = 0; i < N_LINES; i++) begin
			lookup_check(cold_tag(i), word);
			check_value("cold fill RESULT", word, result_word(1'b0, i));
		end
	endtask

	task automatic test_repeat_hits();
		int          order [4] = '{3, 0, 6, 1};
		logic [31:0] word;
		for (int k = 0; k < 4; k++) begin
			lookup_check(cold_tag(order[k]), word);
			check_value("repeat hit flag", 32'(word[8]), 32'h1);
		end
	endtask

	task automatic test_lru_evict();
		logic [31:0] word;
		int          lru_line;
		tag_t        old_tag;
		lookup_check(cold_tag(2), word);
		lookup_check(cold_tag(4), word);
		lookup_check(cold_tag(0), word);
		lru_line = 0;
		for (int i = 0; i < N_LINES; i++) begin
			if (mdl_rank[i] == N_LINES - 1) begin
				lru_line = i;
			end
		end
		old_tag = mdl_tag[lru_line];
		lookup_check(12'hABC, word);
		check_value("evicted line", word, result_word(1'b0, lru_line));
		// the old tag is gone
		lookup_check(old_tag, word);
		check_value("evicted tag hit flag", 32'(word[8]), 32'h0);
	endtask

	task automatic test_back_pressure();
		tag_t        tags [BP_LOOKUPS] = '{12'h100, 12'hD01, 12'h111, 12'hD02,
			12'hABC, 12'hD03, 12'h133, 12'hD01};
		logic [31:0] expected [$];
		logic [31:0] data;
		logic        err;
		logic        hit;
		int          line;
		int          accepted;
		int          attempts;
		accepted = 0;
		attempts = 0;
		// a rejected write is retried and left out of the model
		while (accepted < BP_LOOKUPS) begin
			attempts++;
			if (attempts > 4 * BP_LOOKUPS) begin
				$display("the request queue kept rejecting lookups");
				stop_run();
			end
			apb_write(REG_LOOKUP, 32'(tags[accepted]), err);
			if (!err) begin
				model_lookup(tags[accepted], hit, line);
				expected.push_back(result_word(hit, line));
				accepted++;
			end
		end
		for (int k = 0; k < 2; k++) begin
			apb_write(REG_LOOKUP, 32'h0EEE, err);
			check_value("pslverr on LOOKUP write when full", 32'(err), 32'h1);
		end
		apb_read(REG_STATUS, data, err);
		check_value("STATUS with both queues full", data, 32'(1 << ST_REQ_FULL));
		// drain in issue order
		while (expected.size() > 0) begin
			wait_result();
			apb_read(REG_RESULT, data, err);
			check_value("pslverr on RESULT read", 32'(err), 32'h0);
			check_value("queued RESULT", data, expected.pop_front());
		end
		// rejected writes left no result behind
		apb_read(REG_STATUS, data, err);
		check_value("STATUS after drain", data, 32'(1 << ST_RES_EMPTY));
	endtask

	task automatic test_random();
		logic [31:0] word;
		tag_t        tag;
		for (int k = 0; k < 60; k++) begin
			// twelve tags over eight lines keeps evicting
			tag = tag_t'(32'h200 + ($urandom % 12));
			lookup_check(tag, word);
		end
	endtask

	// main sequence
	// --------------------
	initial begin
		resetn  = 1'b0;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		void'($urandom(RAND_SEED));
		model_reset();
		repeat (2) @(negedge clock);
		resetn = 1'b1;

		test_after_reset();
		test_cold_fill();
		test_repeat_hits();
		test_lru_evict();
		test_back_pressure();
		test_random();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- filelist.f
cache_geom_pkg.sv
apb_map_pkg.sv
priority_encoder.sv
line_replacement_ctrl.sv
sync_fifo.sv
apb_lookup_port.sv
tag_lookup_engine.sv
cache_tag_top.sv
tb_cache_tag.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cache_tag --Mdir obj_dir -o sim_cache_tag \
	-f filelist.f

# the log decides pass or fail
./obj_dir/sim_cache_tag 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished without a failure"
